// File: verilog/frontend_pkg.sv
package frontend_pkg;

  // fetch and decode width
  localparam int num_lanes = 2;

  // fetch buffer
  localparam int fb_depth = 8;
  localparam int fb_ptr_bits = $clog2(fb_depth);

  // instruction memory
  localparam int imem_words = 64;
  localparam int imem_addr_bits = $clog2(imem_words);

  // byte address for pc and targets
  typedef logic [31:0] addr_t;

  // raw instruction word
  typedef logic [31:0] inst_t;

  // index into the fetch buffer ring
  typedef logic [fb_ptr_bits-1:0] fb_ptr_t;

  // word index into the instruction memory, address bits 7:2
  typedef logic [imem_addr_bits-1:0] imem_addr_t;

  // top six bits of an unconditional jump
  localparam logic [5:0] jump_opcode = 6'b000010;

  // fetch pc after reset
  localparam addr_t reset_pc = 32'h0000_0000;

endpackage

// File: verilog/fetch_lane_if.sv
interface fetch_lane_if import frontend_pkg::*; ();

  addr_t                pc     [num_lanes];
  inst_t                inst   [num_lanes];
  addr_t                target [num_lanes];
  logic [num_lanes-1:0] valid;     // per lane, 10 never occurs
  logic                 fetch_en;  // buffer has room for the lanes

  modport source (
    output pc,
    output inst,
    output target,
    output valid,
    input  fetch_en
  );

  modport sink (
    input  pc,
    input  inst,
    input  target,
    input  valid,
    output fetch_en
  );

endinterface

// File: verilog/inst_mem.sv
module inst_mem import frontend_pkg::*; (
  input  logic       clock,
  input  logic       write_en,
  input  imem_addr_t write_addr,
  input  inst_t      write_data,
  input  imem_addr_t read_addr0,
  input  imem_addr_t read_addr1,
  output inst_t      read_data0,
  output inst_t      read_data1
);

  inst_t mem [imem_words];

  // one word per clock from the load port
  always_ff @(posedge clock) begin
    if (write_en) begin
      mem[write_addr] <= write_data;
    end
  end

  assign read_data0 = mem[read_addr0];  // async read
  assign read_data1 = mem[read_addr1];

endmodule

// File: verilog/fetch_stage.sv
module fetch_stage import frontend_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       enable,
  input  logic       rollback,
  input  addr_t      rollback_pc,
  output imem_addr_t imem_addr0,
  output imem_addr_t imem_addr1,
  input  inst_t      imem_data0,
  input  inst_t      imem_data1,
  fetch_lane_if.source lanes
);

  addr_t                fetch_pc;
  addr_t                next_pc;
  addr_t                lane_pc     [num_lanes];
  inst_t                lane_inst   [num_lanes];
  addr_t                lane_target [num_lanes];
  logic [num_lanes-1:0] lane_jump;

  function automatic logic is_jump(inst_t inst);
    return inst[31:26] == jump_opcode;
  endfunction

  // jump: own pc plus 4 * sext(imm26), otherwise fall through
  function automatic addr_t target_of(addr_t pc, inst_t inst);
    addr_t offset;
    offset = addr_t'({{6{inst[25]}}, inst[25:0]}) << 2;
    if (is_jump(inst)) begin
      return pc + offset;
    end
    return pc + addr_t'(4);
  endfunction

  // lane pcs are consecutive words
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lane_pc[i] = fetch_pc + addr_t'(4 * i);
    end
  end

  // word index wraps around the memory
  assign imem_addr0 = lane_pc[0][7:2];
  assign imem_addr1 = lane_pc[1][7:2];

  assign lane_inst[0] = imem_data0;
  assign lane_inst[1] = imem_data1;

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lane_jump[i]   = is_jump(lane_inst[i]);
      lane_target[i] = target_of(lane_pc[i], lane_inst[i]);
    end
  end

  // a jump in lane 0 kills lane 1
  assign lanes.valid = {~lane_jump[0], 1'b1};

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lanes.pc[i]     = lane_pc[i];
      lanes.inst[i]   = lane_inst[i];
      lanes.target[i] = lane_target[i];
    end
  end

  assign next_pc = lane_jump[0] ? lane_target[0] : fetch_pc + addr_t'(8);

  always_ff @(posedge clock) begin
    if (reset) begin
      fetch_pc <= reset_pc;
    end else if (enable) begin
      if (rollback) begin
        fetch_pc <= rollback_pc;
      end else if (lanes.fetch_en) begin
        fetch_pc <= next_pc;  // lanes accepted
      end
    end
  end

endmodule

// File: verilog/fetch_buffer.sv
module fetch_buffer import frontend_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  enable,
  input  logic  rollback,
  fetch_lane_if.sink lanes,
  input  logic  get_next_inst,
  output addr_t out_pc0,
  output addr_t out_pc1,
  output inst_t out_inst0,
  output inst_t out_inst1,
  output addr_t out_target0,
  output addr_t out_target1,
  output logic  out_valid
);

  // payload kept as parallel arrays
  addr_t pc_q     [fb_depth];
  inst_t inst_q   [fb_depth];
  addr_t target_q [fb_depth];

  logic [fb_depth-1:0] valid_q;
  logic [fb_depth-1:0] valid_d;
  fb_ptr_t             head;
  fb_ptr_t             tail;
  fb_ptr_t             head_d;
  fb_ptr_t             tail_d;
  fb_ptr_t             head_p1;
  fb_ptr_t             tail_p1;
  logic                one_lane;
  logic                two_lanes;
  logic                pop;

  assign head_p1 = head + fb_ptr_t'(1);
  assign tail_p1 = tail + fb_ptr_t'(1);

  assign one_lane  = lanes.valid == 2'b01;
  assign two_lanes = lanes.valid == 2'b11;

  // room check on the head slots only
  assign lanes.fetch_en = ((one_lane & ~valid_q[head]) |
                           (two_lanes & ~valid_q[head] & ~valid_q[head_p1])) & ~rollback;

  // two oldest entries go out as a pair
  assign out_pc0     = pc_q[tail];
  assign out_pc1     = pc_q[tail_p1];
  assign out_inst0   = inst_q[tail];
  assign out_inst1   = inst_q[tail_p1];
  assign out_target0 = target_q[tail];
  assign out_target1 = target_q[tail_p1];
  assign out_valid   = valid_q[tail] & valid_q[tail_p1];

  assign pop = get_next_inst & out_valid;

  // push and pop never touch the same slot
  always_comb begin
    valid_d = valid_q;
    head_d  = head;
    tail_d  = tail;
    if (pop) begin
      valid_d[tail]    = 1'b0;
      valid_d[tail_p1] = 1'b0;
      tail_d           = tail + fb_ptr_t'(2);
    end
    if (lanes.fetch_en) begin
      valid_d[head] = 1'b1;
      head_d        = head_p1;
      if (two_lanes) begin
        valid_d[head_p1] = 1'b1;
        head_d           = head + fb_ptr_t'(2);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
      head    <= '0;
      tail    <= '0;
    end else if (enable) begin
      if (rollback) begin
        valid_q <= '0;  // flush
        head    <= '0;
        tail    <= '0;
      end else begin
        valid_q <= valid_d;
        head    <= head_d;
        tail    <= tail_d;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (enable && lanes.fetch_en) begin
      pc_q[head]     <= lanes.pc[0];
      inst_q[head]   <= lanes.inst[0];
      target_q[head] <= lanes.target[0];
      if (two_lanes) begin
        pc_q[head_p1]     <= lanes.pc[1];
        inst_q[head_p1]   <= lanes.inst[1];
        target_q[head_p1] <= lanes.target[1];
      end
    end
  end

endmodule

// File: verilog/frontend_top.sv
module frontend_top import frontend_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       enable,
  input  logic       imem_write_en,
  input  imem_addr_t imem_write_addr,
  input  inst_t      imem_write_data,
  input  logic       rollback,
  input  addr_t      rollback_pc,
  input  logic       get_next_inst,
  output addr_t      decode_pc0,
  output addr_t      decode_pc1,
  output inst_t      decode_inst0,
  output inst_t      decode_inst1,
  output addr_t      decode_target0,
  output addr_t      decode_target1,
  output logic       decode_valid
);

  imem_addr_t imem_addr0;
  imem_addr_t imem_addr1;
  inst_t      imem_data0;
  inst_t      imem_data1;

  fetch_lane_if lanes_if ();

  inst_mem u_imem (
    .clock      (clock),
    .write_en   (imem_write_en),
    .write_addr (imem_write_addr),
    .write_data (imem_write_data),
    .read_addr0 (imem_addr0),
    .read_addr1 (imem_addr1),
    .read_data0 (imem_data0),
    .read_data1 (imem_data1)
  );

  fetch_stage u_fetch (
    .clock       (clock),
    .reset       (reset),
    .enable      (enable),
    .rollback    (rollback),
    .rollback_pc (rollback_pc),
    .imem_addr0  (imem_addr0),
    .imem_addr1  (imem_addr1),
    .imem_data0  (imem_data0),
    .imem_data1  (imem_data1),
    .lanes       (lanes_if.source)
  );

  fetch_buffer u_fb (
    .clock         (clock),
    .reset         (reset),
    .enable        (enable),
    .rollback      (rollback),
    .lanes         (lanes_if.sink),
    .get_next_inst (get_next_inst),
    .out_pc0       (decode_pc0),
    .out_pc1       (decode_pc1),
    .out_inst0     (decode_inst0),
    .out_inst1     (decode_inst1),
    .out_target0   (decode_target0),
    .out_target1   (decode_target1),
    .out_valid     (decode_valid)
  );

endmodule

// File: verif/frontend_checker.sv
module frontend_checker import frontend_pkg::*; (
  input logic                clock,
  input logic                reset,
  input logic                enable,
  input logic                rollback,
  input logic                fetch_en,
  input logic                out_valid,
  input logic [fb_depth-1:0] valid_q,
  input fb_ptr_t             head,
  input fb_ptr_t             tail
);

  // a flush edge leaves nothing for decode
  flush_empties_buffer: assert property (
    @(posedge clock) (reset || (enable && rollback)) |=> !out_valid
  ) else $error("out_valid high in the cycle after a reset or rollback edge");

  no_fetch_during_rollback: assert property (
    @(posedge clock) disable iff (reset) rollback |-> !fetch_en
  ) else $error("fetch_en high while rollback is high");

  // valid entries run from tail up to head, full when they meet
  occupancy_matches_pointers: assert property (
    @(posedge clock) disable iff (reset)
      $countones(valid_q) == ((head == tail && valid_q[tail]) ? fb_depth
                                                               : int'(fb_ptr_t'(head - tail)))
  ) else $error("valid entry count does not match head and tail");

endmodule

// File: verif/frontend_tb.sv
module frontend_tb import frontend_pkg::*; ();

  localparam int num_tests      = 6;
  localparam int pairs_per_test = 40;
  localparam int run_budget     = 300;

  // kind 0 straight, 1 jumps, 2 random; pop 0 every cycle, 1 every other, 2 after cycle 40
  int    kind_tab   [num_tests] = '{0, 0, 1, 0, 1, 2};
  int    pop_tab    [num_tests] = '{0, 2, 1, 0, 0, 1};
  int    rb_cyc_tab [num_tests] = '{0, 0, 0, 15, 0, 30};
  addr_t rb_pc_tab  [num_tests] = '{32'h0, 32'h0, 32'h0, 32'h84, 32'h0, 32'h20};
  int    en_at_tab  [num_tests] = '{0, 0, 0, 0, 12, 50};
  int    en_len_tab [num_tests] = '{0, 0, 0, 0, 6, 4};

  logic       clock;
  logic       reset;
  logic       enable;
  logic       imem_write_en;
  imem_addr_t imem_write_addr;
  inst_t      imem_write_data;
  logic       rollback;
  addr_t      rollback_pc;
  logic       get_next_inst;
  addr_t      decode_pc0;
  addr_t      decode_pc1;
  inst_t      decode_inst0;
  inst_t      decode_inst1;
  addr_t      decode_target0;
  addr_t      decode_target1;
  logic       decode_valid;

  inst_t       prog [imem_words];
  addr_t       exp_pc [$];
  inst_t       exp_inst [$];
  addr_t       exp_tgt [$];
  addr_t       model_pc;
  logic [192:0] held;
  int          errors;
  int          test_errors;
  int          checks;
  int          tests_failed;

  frontend_top dut (.*);

  bind fetch_buffer frontend_checker fb_checks (
    .clock     (clock),
    .reset     (reset),
    .enable    (enable),
    .rollback  (rollback),
    .fetch_en  (lanes.fetch_en),
    .out_valid (out_valid),
    .valid_q   (valid_q),
    .head      (head),
    .tail      (tail)
  );

  always #4 clock = ~clock;

  function automatic inst_t straight_word(int w);
    logic [17:0] mix;
    mix = 18'(w * 2731 + 77);
    return {6'h23, 2'b01, mix, 6'(w)};  // never the jump opcode
  endfunction

  function automatic inst_t jump_word(int off);
    return {jump_opcode, 26'(off)};
  endfunction

  // pc + 4 * sext(imm26) for jumps, else next word
  function automatic addr_t expected_target(addr_t pc, inst_t w);
    int off;
    off = int'($signed(w[25:0]));
    if (w[31:26] == jump_opcode) begin
      return pc + addr_t'(off * 4);
    end
    return pc + 32'd4;
  endfunction

  function automatic logic [192:0] decode_snapshot();
    return {decode_valid, decode_pc0, decode_pc1, decode_inst0, decode_inst1,
            decode_target0, decode_target1};
  endfunction

  task automatic build_program(int kind);
    for (int w = 0; w < imem_words; w++) begin
      case (kind)
        1: begin
          if (w % 16 == 6) begin
            prog[w] = jump_word(6);
          end else if (w % 16 == 14) begin
            prog[w] = jump_word(4);
          end else begin
            prog[w] = straight_word(w);
          end
        end
        2: begin
          if ($urandom_range(3, 0) == 0) begin
            prog[w] = {jump_opcode, 26'($urandom)};
          end else begin
            prog[w] = $urandom;
          end
        end
        default: prog[w] = straight_word(w);
      endcase
    end
  endtask

  task automatic append_entry(addr_t pc);
    inst_t w;
    w = prog[pc[7:2]];  // memory wraps on the word index
    exp_pc.push_back(pc);
    exp_inst.push_back(w);
    exp_tgt.push_back(expected_target(pc, w));
  endtask

  // one fetch group of the reference stream
  task automatic advance_model();
    inst_t w0;
    w0 = prog[model_pc[7:2]];
    append_entry(model_pc);
    if (w0[31:26] == jump_opcode) begin
      model_pc = expected_target(model_pc, w0);  // lane 1 dropped
    end else begin
      append_entry(model_pc + 32'd4);
      model_pc = model_pc + 32'd8;
    end
  endtask

  task automatic restart_model(addr_t pc);
    exp_pc.delete();
    exp_inst.delete();
    exp_tgt.delete();
    model_pc = pc;
  endtask

  task automatic check_entry(int lane, addr_t pc, inst_t w, addr_t tgt);
    addr_t e_pc;
    inst_t e_inst;
    addr_t e_tgt;
    while (exp_pc.size() == 0) begin
      advance_model();
    end
    e_pc   = exp_pc.pop_front();
    e_inst = exp_inst.pop_front();
    e_tgt  = exp_tgt.pop_front();
    checks++;
    if (pc !== e_pc || w !== e_inst || tgt !== e_tgt) begin
      errors++;
      test_errors++;
      $display("[FAIL] %0t: lane %0d got pc %h inst %h target %h", $time, lane, pc, w, tgt);
      $display("[FAIL] %0t: expected pc %h inst %h target %h", $time, e_pc, e_inst, e_tgt);
    end
  endtask

  task automatic run_test(int t);
    int   popped;
    int   cyc;
    logic want;
    logic in_window;
    logic do_rb;
    test_errors = 0;
    popped      = 0;
    build_program(kind_tab[t]);
    restart_model(reset_pc);
    // reset for the first 10 load cycles, then frozen until loaded
    for (int w = 0; w < imem_words; w++) begin
      @(negedge clock);
      if (w == 9 && decode_valid !== 1'b0) begin
        errors++;
        test_errors++;
        $display("[FAIL] %0t: decode_valid high during reset", $time);
      end
      reset           = (w < 10);
      enable          = (w < 10);
      imem_write_en   = 1'b1;
      imem_write_addr = imem_addr_t'(w);
      imem_write_data = prog[w];
    end
    @(negedge clock);
    imem_write_en = 1'b0;
    enable        = 1'b1;
    checks++;
    if (decode_valid !== 1'b0) begin
      errors++;
      test_errors++;
      $display("[FAIL] %0t: decode_valid high right after reset", $time);
    end
    cyc = 0;
    while (popped < pairs_per_test && cyc < run_budget) begin
      @(negedge clock);
      in_window = (en_len_tab[t] > 0) && (cyc >= en_at_tab[t]) &&
                  (cyc < en_at_tab[t] + en_len_tab[t]);
      do_rb     = (rb_cyc_tab[t] > 0) && (cyc == rb_cyc_tab[t]);
      case (pop_tab[t])
        1:       want = (cyc % 2 == 0);
        2:       want = (cyc >= 40);  // buffer fills first
        default: want = 1'b1;
      endcase
      enable        = ~in_window;
      rollback      = do_rb;
      rollback_pc   = rb_pc_tab[t];
      get_next_inst = (want | in_window) & ~do_rb;
      if (in_window) begin
        if (cyc == en_at_tab[t]) begin
          held = decode_snapshot();
        end else begin
          checks++;
          if (decode_snapshot() !== held) begin
            errors++;
            test_errors++;
            $display("[FAIL] %0t: decode outputs changed while enable was low", $time);
          end
        end
      end else if (do_rb) begin
        restart_model(rb_pc_tab[t]);
      end else if (get_next_inst && decode_valid) begin
        check_entry(0, decode_pc0, decode_inst0, decode_target0);
        check_entry(1, decode_pc1, decode_inst1, decode_target1);
        popped++;
      end
      cyc++;
    end
    @(negedge clock);
    get_next_inst = 1'b0;
    rollback      = 1'b0;
    enable        = 1'b1;
    if (popped < pairs_per_test) begin
      errors++;
      test_errors++;
      $display("test %0d: only %0d of %0d pairs reached decode in time", t, popped,
               pairs_per_test);
    end
    if (test_errors == 0) begin
      $display("test %0d passed, %0d pairs checked", t, popped);
    end else begin
      tests_failed++;
      $display("test %0d failed with %0d errors", t, test_errors);
    end
  endtask

  initial begin
    void'($urandom(24));
    clock           = 1'b0;
    reset           = 1'b1;
    enable          = 1'b1;
    imem_write_en   = 1'b0;
    imem_write_addr = '0;
    imem_write_data = '0;
    rollback        = 1'b0;
    rollback_pc     = '0;
    get_next_inst   = 1'b0;
    errors          = 0;
    checks          = 0;
    tests_failed    = 0;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, failed %0d, checks %0d, errors %0d", num_tests, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog scaled to the table length
  initial begin
    #(num_tests * 400 * 8);
    $display("watchdog expired before all tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: verilog.f
verilog/frontend_pkg.sv
verilog/fetch_lane_if.sv
verilog/inst_mem.sv
verilog/fetch_stage.sv
verilog/fetch_buffer.sv
verilog/frontend_top.sv
verif/frontend_checker.sv
verif/frontend_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = frontend_tb
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
